// ==== mempool_system.f ====
+incdir+verification
rtl/axi_lite_pkg.sv
rtl/mempool_system_pkg.sv
rtl/axi_lite_if.sv
rtl/axi_lite_addr_demux.sv
rtl/axi_lite_to_mem.sv
rtl/l2_sram.sv
rtl/bootrom.sv
rtl/ctrl_registers.sv
rtl/mempool_system.sv
verification/mempool_system_tb.sv

// ==== verification/tb_axi_lite_tasks.svh ====
`ifndef TB_AXI_LITE_TASKS_SVH
`define TB_AXI_LITE_TASKS_SVH

// Both tasks start and end on a falling edge of clk_i
task automatic host_write(input addr_t addr, input data_t data, input strb_t strb,
                          output resp_t resp);
  bit done;
  int hold;
  hold        = $urandom_range(0, stall_max);
  s_awaddr_i  = addr;
  s_awvalid_i = 1'b1;
  s_wdata_i   = data;
  s_wstrb_i   = strb;
  s_wvalid_i  = 1'b1;
  forever begin
    #(settle_delay);
    done = s_awready_o && s_wready_o;
    @(negedge clk_i);
    if (done) break;
  end
  s_awvalid_i = 1'b0;
  s_wvalid_i  = 1'b0;
  // Bready held off for a few cycles on the response channel
  forever begin
    s_bready_i = (hold == 0);
    #(settle_delay);
    done = s_bvalid_o && s_bready_i;
    resp = s_bresp_o;
    if (s_bvalid_o && hold > 0) hold--;
    @(negedge clk_i);
    if (done) break;
  end
  s_bready_i = 1'b0;
endtask

task automatic host_read(input addr_t addr, output data_t data, output resp_t resp);
  bit done;
  int hold;
  hold        = $urandom_range(0, stall_max);
  s_araddr_i  = addr;
  s_arvalid_i = 1'b1;
  forever begin
    #(settle_delay);
    done = s_arready_o;
    @(negedge clk_i);
    if (done) break;
  end
  s_arvalid_i = 1'b0;
  forever begin
    s_rready_i = (hold == 0);
    #(settle_delay);
    done = s_rvalid_o && s_rready_i;
    data = s_rdata_o;
    resp = s_rresp_o;
    if (s_rvalid_o && hold > 0) hold--;
    @(negedge clk_i);
    if (done) break;
  end
  s_rready_i = 1'b0;
endtask

`endif

// ==== verification/mempool_system_tb.sv ====
`timescale 1ns/10ps

module mempool_system_tb;
  import axi_lite_pkg::*;
  import mempool_system_pkg::*;

  localparam int          clk_period       = 4;
  localparam int          settle_delay     = 1;
  localparam int unsigned num_cores        = 4;
  localparam int unsigned banking_factor   = 4;
  localparam addr_t       tcdm_base_addr   = 32'h0000_0000;
  localparam int unsigned l2_num_words     = 1024;
  localparam addr_t       tcdm_end         = tcdm_base_addr + num_cores * banking_factor * 1024 - 1;
  localparam int          num_transactions = 164;
  localparam int          watchdog_cycles  = num_transactions * 200 + 16;

  logic                 clk_i;
  logic                 reset_i;
  addr_t                s_awaddr_i;
  logic                 s_awvalid_i;
  logic                 s_awready_o;
  data_t                s_wdata_i;
  strb_t                s_wstrb_i;
  logic                 s_wvalid_i;
  logic                 s_wready_o;
  resp_t                s_bresp_o;
  logic                 s_bvalid_o;
  logic                 s_bready_i;
  addr_t                s_araddr_i;
  logic                 s_arvalid_i;
  logic                 s_arready_o;
  data_t                s_rdata_o;
  resp_t                s_rresp_o;
  logic                 s_rvalid_o;
  logic                 s_rready_i;
  logic [num_cores-1:0] wake_up_o;
  logic                 busy_o;
  logic                 eoc_valid_o;

  // Reference state
  data_t l2_model [int unsigned];
  data_t eoc_model       = '0;
  logic  busy_model      = 1'b0;
  logic  eoc_valid_model = 1'b0;

  int                   stall_max      = 2;
  int                   total_checks   = 0;
  int                   total_errors   = 0;
  int                   test_checks    = 0;
  int                   test_errors    = 0;
  int                   wake_cycles    = 0;
  logic [num_cores-1:0] last_wake_bits = '0;
  int unsigned          l2_words [$];

  `include "tb_axi_lite_tasks.svh"

  mempool_system #(
    .num_cores     (num_cores     ),
    .banking_factor(banking_factor),
    .tcdm_base_addr(tcdm_base_addr),
    .l2_num_words  (l2_num_words  )
  ) dut (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .s_awaddr_i (s_awaddr_i ),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i  ),
    .s_wstrb_i  (s_wstrb_i  ),
    .s_wvalid_i (s_wvalid_i ),
    .s_wready_o (s_wready_o ),
    .s_bresp_o  (s_bresp_o  ),
    .s_bvalid_o (s_bvalid_o ),
    .s_bready_i (s_bready_i ),
    .s_araddr_i (s_araddr_i ),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o  ),
    .s_rresp_o  (s_rresp_o  ),
    .s_rvalid_o (s_rvalid_o ),
    .s_rready_i (s_rready_i ),
    .wake_up_o  (wake_up_o  ),
    .busy_o     (busy_o     ),
    .eoc_valid_o(eoc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Counts cycles with any wake-up bit high
  always @(negedge clk_i) begin
    if (|wake_up_o) begin
      wake_cycles++;
      last_wake_bits = wake_up_o;
    end
  end

  function automatic data_t merge_bytes(data_t old_word, data_t data, strb_t strb);
    data_t word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    return word;
  endfunction

  function automatic resp_t model_write(addr_t addr, data_t data, strb_t strb);
    logic [num_cores-1:0] bits;
    int unsigned          idx;
    if (addr >= ctrl_base_addr && addr <= ctrl_end_addr) begin
      if (addr[15:0] == reg_eoc_off) begin
        eoc_model = merge_bytes(eoc_model, data, strb);
        if (eoc_model != '0) begin
          eoc_valid_model = 1'b1;
          busy_model      = 1'b0;
        end
        return resp_okay;
      end
      if (addr[15:0] == reg_wake_up_off) begin
        bits = data[num_cores-1:0];
        if (|bits) begin
          busy_model      = 1'b1;
          eoc_valid_model = 1'b0;
        end
        return resp_okay;
      end
      return resp_slverr;
    end
    if (addr >= l2_base_addr && addr <= l2_end_addr) begin
      idx = (addr - l2_base_addr) >> 2;
      l2_model[idx] = merge_bytes(l2_model.exists(idx) ? l2_model[idx] : '0, data, strb);
      return resp_okay;
    end
    if (addr >= bootrom_base_addr && addr <= bootrom_end_addr) return resp_slverr;
    return resp_decerr;
  endfunction

  function automatic resp_t model_read(addr_t addr, output data_t data);
    int unsigned idx;
    data = '0;
    if (addr >= ctrl_base_addr && addr <= ctrl_end_addr) begin
      case (addr[15:0])
        reg_eoc_off:        data = eoc_model;
        reg_wake_up_off:    data = '0;
        reg_tcdm_start_off: data = tcdm_base_addr;
        reg_tcdm_end_off:   data = tcdm_end;
        reg_num_cores_off:  data = num_cores;
        reg_busy_off:       data = data_t'(busy_model);
        default:            return resp_slverr;
      endcase
      return resp_okay;
    end
    if (addr >= l2_base_addr && addr <= l2_end_addr) begin
      idx  = (addr - l2_base_addr) >> 2;
      data = l2_model.exists(idx) ? l2_model[idx] : '0;
      return resp_okay;
    end
    if (addr >= bootrom_base_addr && addr <= bootrom_end_addr) begin
      data = bootrom_pattern | ((addr - bootrom_base_addr) >> 2);
      return resp_okay;
    end
    return resp_decerr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    total_checks++;
    test_checks++;
    if (got !== exp) begin
      total_errors++;
      test_errors++;
      $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic write_expect(input addr_t addr, input data_t data, input strb_t strb);
    resp_t exp_resp;
    resp_t got_resp;
    exp_resp = model_write(addr, data, strb);
    host_write(addr, data, strb, got_resp);
    check_value($sformatf("bresp @%08h", addr), got_resp, exp_resp);
  endtask

  task automatic read_expect(input addr_t addr);
    resp_t exp_resp;
    resp_t got_resp;
    data_t exp_data;
    data_t got_data;
    exp_resp = model_read(addr, exp_data);
    host_read(addr, got_data, got_resp);
    check_value($sformatf("rresp @%08h", addr), got_resp, exp_resp);
    if (exp_resp != resp_slverr) begin
      check_value($sformatf("rdata @%08h", addr), got_data, exp_data);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %-14s %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    int unsigned idx;
    int          wake_before;
    addr_t       addr;
    void'($urandom(32'h5a020c4e));
    reset_i     = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_value("wake_up_o", wake_up_o, '0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("eoc_valid_o", eoc_valid_o, 1'b0);
    check_value("s_bvalid_o", s_bvalid_o, 1'b0);
    check_value("s_rvalid_o", s_rvalid_o, 1'b0);
    report_test("reset");

    // Full word first so later partial writes merge into known data
    for (int i = 0; i < 16; i++) begin
      l2_words.push_back($urandom_range(0, l2_num_words - 1));
      write_expect(l2_base_addr + 4 * l2_words[i], $urandom, 4'hF);
    end
    for (int i = 0; i < 32; i++) begin
      idx = l2_words[$urandom_range(0, 15)];
      write_expect(l2_base_addr + 4 * idx, $urandom, strb_t'($urandom_range(0, 15)));
    end
    for (int i = 0; i < 32; i++) begin
      read_expect(l2_base_addr + 4 * l2_words[$urandom_range(0, 15)]);
    end
    report_test("l2");

    for (int i = 0; i < 16; i++) begin
      read_expect(bootrom_base_addr + 4 * $urandom_range(0, bootrom_num_words - 1));
    end
    for (int i = 0; i < 4; i++) begin
      addr = bootrom_base_addr + 4 * $urandom_range(0, bootrom_num_words - 1);
      write_expect(addr, $urandom, 4'hF);
      read_expect(addr);
    end
    report_test("bootrom");

    read_expect(ctrl_base_addr + reg_tcdm_start_off);
    read_expect(ctrl_base_addr + reg_tcdm_end_off);
    read_expect(ctrl_base_addr + reg_num_cores_off);
    write_expect(ctrl_base_addr + reg_tcdm_start_off, $urandom, 4'hF);
    write_expect(ctrl_base_addr + reg_tcdm_end_off, $urandom, 4'hF);
    write_expect(ctrl_base_addr + reg_num_cores_off, $urandom, 4'hF);
    write_expect(ctrl_base_addr + 32'h18, $urandom, 4'hF);
    read_expect(ctrl_base_addr + 32'h18);
    read_expect(ctrl_base_addr + reg_tcdm_end_off);
    report_test("read-only regs");

    wake_before = wake_cycles;
    write_expect(ctrl_base_addr + reg_wake_up_off, 32'h0000_00A5, 4'hF);
    repeat (2) @(negedge clk_i);
    check_value("wake_up_o cycles", wake_cycles - wake_before, 1);
    check_value("wake_up_o", last_wake_bits, 32'h0000_00A5 & ((1 << num_cores) - 1));
    check_value("busy_o", busy_o, busy_model);
    check_value("eoc_valid_o", eoc_valid_o, eoc_valid_model);
    read_expect(ctrl_base_addr + reg_busy_off);
    write_expect(ctrl_base_addr + reg_eoc_off, 32'h0000_002A, 4'h1);
    check_value("busy_o", busy_o, busy_model);
    check_value("eoc_valid_o", eoc_valid_o, eoc_valid_model);
    read_expect(ctrl_base_addr + reg_eoc_off);
    read_expect(ctrl_base_addr + reg_busy_off);
    report_test("wake/eoc");

    read_expect(32'h0000_1000);
    write_expect(32'h0000_1000, $urandom, 4'hF);
    read_expect(32'hC000_0000);
    write_expect(l2_end_addr + 1, $urandom, 4'hF);
    write_expect(l2_base_addr + 4 * l2_words[0], $urandom, 4'hF);
    read_expect(l2_base_addr + 4 * l2_words[0]);
    report_test("unmapped");

    // Long ready stalls on b and r
    stall_max = 8;
    for (int i = 0; i < 40; i++) begin
      idx = l2_words[$urandom_range(0, 15)];
      case ($urandom_range(0, 3))
        0:       write_expect(l2_base_addr + 4 * idx, $urandom, strb_t'($urandom_range(0, 15)));
        1:       read_expect(l2_base_addr + 4 * idx);
        2:       read_expect(bootrom_base_addr + 4 * $urandom_range(0, bootrom_num_words - 1));
        default: read_expect(ctrl_base_addr + 4 * $urandom_range(0, 5));
      endcase
    end
    report_test("back-pressure");

    $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Watchdog expired at %0t ns, a bus handshake never completed", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== rtl/mempool_system.sv ====
`timescale 1ns/10ps

module mempool_system #(
  parameter int unsigned         num_cores      = 4,
  parameter int unsigned         banking_factor = 4,
  parameter axi_lite_pkg::addr_t tcdm_base_addr = 32'h0000_0000,
  parameter int unsigned         l2_num_words   = 1024
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  axi_lite_pkg::addr_t  s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  axi_lite_pkg::data_t  s_wdata_i,
  input  axi_lite_pkg::strb_t  s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  output axi_lite_pkg::resp_t  s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  input  axi_lite_pkg::addr_t  s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  output axi_lite_pkg::data_t  s_rdata_o,
  output axi_lite_pkg::resp_t  s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i,
  output logic [num_cores-1:0] wake_up_o,
  output logic                 busy_o,
  output logic                 eoc_valid_o
);
  import axi_lite_pkg::*;
  import mempool_system_pkg::*;

  // One KiB of TCDM per bank
  localparam addr_t tcdm_end_addr =
    addr_t'(tcdm_base_addr + num_cores * banking_factor * 1024 - 1);
  localparam int unsigned l2_addr_bits  = $clog2(l2_num_words);
  localparam int unsigned rom_addr_bits = $clog2(bootrom_num_words);

  logic                    l2_req;
  logic                    l2_we;
  logic [l2_addr_bits-1:0] l2_addr;
  data_t                   l2_wdata;
  strb_t                   l2_be;
  data_t                   l2_rdata;
  logic                     rom_req;
  logic [rom_addr_bits-1:0] rom_addr;
  data_t                    rom_rdata;

  axi_lite_if host_bus ();
  axi_lite_if ctrl_bus ();
  axi_lite_if l2_bus ();
  axi_lite_if rom_bus ();

  assign host_bus.awaddr  = s_awaddr_i;
  assign host_bus.awvalid = s_awvalid_i;
  assign host_bus.wdata   = s_wdata_i;
  assign host_bus.wstrb   = s_wstrb_i;
  assign host_bus.wvalid  = s_wvalid_i;
  assign host_bus.bready  = s_bready_i;
  assign host_bus.araddr  = s_araddr_i;
  assign host_bus.arvalid = s_arvalid_i;
  assign host_bus.rready  = s_rready_i;
  assign s_awready_o      = host_bus.awready;
  assign s_wready_o       = host_bus.wready;
  assign s_bresp_o        = host_bus.bresp;
  assign s_bvalid_o       = host_bus.bvalid;
  assign s_arready_o      = host_bus.arready;
  assign s_rdata_o        = host_bus.rdata;
  assign s_rresp_o        = host_bus.rresp;
  assign s_rvalid_o       = host_bus.rvalid;

  axi_lite_addr_demux i_demux (
    .clk_i   (clk_i   ),
    .reset_i (reset_i ),
    .slv     (host_bus),
    .ctrl_mst(ctrl_bus),
    .l2_mst  (l2_bus  ),
    .rom_mst (rom_bus )
  );

  ctrl_registers #(
    .num_cores (num_cores     ),
    .tcdm_start(tcdm_base_addr),
    .tcdm_end  (tcdm_end_addr )
  ) i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .slv        (ctrl_bus   ),
    .wake_up_o  (wake_up_o  ),
    .busy_o     (busy_o     ),
    .eoc_valid_o(eoc_valid_o)
  );

  axi_lite_to_mem #(
    .num_words(l2_num_words),
    .read_only(1'b0        )
  ) i_l2_adapter (
    .clk_i      (clk_i   ),
    .reset_i    (reset_i ),
    .slv        (l2_bus  ),
    .mem_req_o  (l2_req  ),
    .mem_we_o   (l2_we   ),
    .mem_addr_o (l2_addr ),
    .mem_wdata_o(l2_wdata),
    .mem_be_o   (l2_be   ),
    .mem_rdata_i(l2_rdata)
  );

  l2_sram #(
    .num_words(l2_num_words)
  ) i_l2_sram (
    .clk_i  (clk_i   ),
    .req_i  (l2_req  ),
    .we_i   (l2_we   ),
    .addr_i (l2_addr ),
    .wdata_i(l2_wdata),
    .be_i   (l2_be   ),
    .rdata_o(l2_rdata)
  );

  // Boot ROM takes no write data
  axi_lite_to_mem #(
    .num_words(bootrom_num_words),
    .read_only(1'b1             )
  ) i_rom_adapter (
    .clk_i      (clk_i    ),
    .reset_i    (reset_i  ),
    .slv        (rom_bus  ),
    .mem_req_o  (rom_req  ),
    .mem_we_o   (         ),
    .mem_addr_o (rom_addr ),
    .mem_wdata_o(         ),
    .mem_be_o   (         ),
    .mem_rdata_i(rom_rdata)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (rom_addr ),
    .rdata_o(rom_rdata)
  );

endmodule

// ==== rtl/ctrl_registers.sv ====
`timescale 1ns/10ps

module ctrl_registers #(
  parameter int unsigned         num_cores  = 4,
  parameter axi_lite_pkg::addr_t tcdm_start = 32'h0000_0000,
  parameter axi_lite_pkg::addr_t tcdm_end   = 32'h0000_3FFF
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  axi_lite_if.slave            slv,
  output logic [num_cores-1:0] wake_up_o,
  output logic                 busy_o,
  output logic                 eoc_valid_o
);
  import axi_lite_pkg::*;
  import mempool_system_pkg::*;

  logic                 wr_acc;
  logic                 rd_acc;
  data_t                eoc_q;
  data_t                eoc_merged;
  logic [num_cores-1:0] wake_bits;

  assign wr_acc      = slv.awvalid && slv.wvalid && !slv.bvalid;
  assign rd_acc      = slv.arvalid && !slv.rvalid;
  assign slv.awready = wr_acc;
  assign slv.wready  = wr_acc;
  assign slv.arready = rd_acc;
  assign wake_bits   = slv.wdata[num_cores-1:0];

  always_comb begin
    eoc_merged = eoc_q;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (slv.wstrb[i]) begin
        eoc_merged[8*i +: 8] = slv.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q       <= '0;
      wake_up_o   <= '0;
      busy_o      <= 1'b0;
      eoc_valid_o <= 1'b0;
      slv.bvalid  <= 1'b0;
      slv.rvalid  <= 1'b0;
    end else begin
      // Wake-up is a single cycle pulse
      wake_up_o <= '0;
      if (wr_acc) begin
        slv.bvalid <= 1'b1;
        slv.bresp  <= resp_okay;
        case (slv.awaddr[15:0])
          reg_eoc_off: begin
            eoc_q <= eoc_merged;
            if (eoc_merged != '0) begin
              eoc_valid_o <= 1'b1;
              busy_o      <= 1'b0;
            end
          end
          reg_wake_up_off: begin
            wake_up_o <= wake_bits;
            if (|wake_bits) begin
              busy_o      <= 1'b1;
              eoc_valid_o <= 1'b0;
            end
          end
          default: slv.bresp <= resp_slverr;
        endcase
      end else if (slv.bready) begin
        slv.bvalid <= 1'b0;
      end
      if (rd_acc) begin
        slv.rvalid <= 1'b1;
        slv.rresp  <= resp_okay;
        case (slv.araddr[15:0])
          reg_eoc_off:        slv.rdata <= eoc_q;
          reg_wake_up_off:    slv.rdata <= '0;
          reg_tcdm_start_off: slv.rdata <= tcdm_start;
          reg_tcdm_end_off:   slv.rdata <= tcdm_end;
          reg_num_cores_off:  slv.rdata <= data_t'(num_cores);
          reg_busy_off:       slv.rdata <= data_t'(busy_o);
          default: begin
            slv.rdata <= '0;
            slv.rresp <= resp_slverr;
          end
        endcase
      end else if (slv.rready) begin
        slv.rvalid <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    |wake_up_o |=> !(|wake_up_o));

endmodule

// ==== rtl/bootrom.sv ====
`timescale 1ns/10ps

module bootrom (
  input  logic                                                  clk_i,
  input  logic                                                  req_i,
  input  logic [$clog2(mempool_system_pkg::bootrom_num_words)-1:0] addr_i,
  output axi_lite_pkg::data_t                                   rdata_o
);
  import axi_lite_pkg::*;
  import mempool_system_pkg::*;

  data_t word;

  // Boot image is the fixed pattern tagged with the word index
  assign word = bootrom_pattern | data_t'(addr_i);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= word;
    end
  end

endmodule

// ==== rtl/l2_sram.sv ====
`timescale 1ns/10ps

module l2_sram #(
  parameter int unsigned num_words = 1024
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(num_words)-1:0] addr_i,
  input  axi_lite_pkg::data_t          wdata_i,
  input  axi_lite_pkg::strb_t          be_i,
  output axi_lite_pkg::data_t          rdata_o
);
  import axi_lite_pkg::*;

  data_t mem [num_words];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
          if (be_i[i]) begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== rtl/axi_lite_to_mem.sv ====
`timescale 1ns/10ps

module axi_lite_to_mem #(
  parameter int unsigned num_words = 1024,
  parameter bit          read_only = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  axi_lite_if.slave                    slv,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [$clog2(num_words)-1:0] mem_addr_o,
  output axi_lite_pkg::data_t          mem_wdata_o,
  output axi_lite_pkg::strb_t          mem_be_o,
  input  axi_lite_pkg::data_t          mem_rdata_i
);
  import axi_lite_pkg::*;

  localparam int unsigned addr_bits = $clog2(num_words);

  logic wr_acc;
  logic rd_acc;
  logic rd_stage;

  // Writes win a tie for the single memory port
  assign wr_acc = slv.awvalid && slv.wvalid && !slv.bvalid;
  assign rd_acc = slv.arvalid && !wr_acc && !rd_stage && !slv.rvalid;

  assign slv.awready = wr_acc;
  assign slv.wready  = wr_acc;
  assign slv.arready = rd_acc;
  assign slv.bresp   = read_only ? resp_slverr : resp_okay;
  assign slv.rresp   = resp_okay;

  // Regions are aligned, so the low word bits are the region offset
  assign mem_req_o   = wr_acc || rd_acc;
  assign mem_we_o    = wr_acc && !read_only;
  assign mem_addr_o  = wr_acc ? slv.awaddr[2 +: addr_bits] : slv.araddr[2 +: addr_bits];
  assign mem_wdata_o = slv.wdata;
  assign mem_be_o    = slv.wstrb;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slv.bvalid <= 1'b0;
      slv.rvalid <= 1'b0;
      rd_stage   <= 1'b0;
    end else begin
      if (wr_acc) begin
        slv.bvalid <= 1'b1;
      end else if (slv.bready) begin
        slv.bvalid <= 1'b0;
      end
      rd_stage <= rd_acc;
      if (rd_stage) begin
        slv.rvalid <= 1'b1;
      end else if (slv.rready) begin
        slv.rvalid <= 1'b0;
      end
    end
  end

  // Capture read data once the memory has answered
  always_ff @(posedge clk_i) begin
    if (rd_stage) begin
      slv.rdata <= mem_rdata_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    slv.rvalid && !slv.rready |=> slv.rvalid && $stable(slv.rdata));

endmodule

// ==== rtl/axi_lite_addr_demux.sv ====
`timescale 1ns/10ps

module axi_lite_addr_demux (
  input logic        clk_i,
  input logic        reset_i,
  axi_lite_if.slave  slv,
  axi_lite_if.master ctrl_mst,
  axi_lite_if.master l2_mst,
  axi_lite_if.master rom_mst
);
  import axi_lite_pkg::*;
  import mempool_system_pkg::*;

  target_e aw_sel;
  target_e ar_sel;
  target_e w_tgt;
  target_e r_tgt;
  logic    w_busy;
  logic    r_busy;

  // Target side handshakes indexed by target_e
  logic  awready_t [4];
  logic  wready_t  [4];
  logic  arready_t [4];
  logic  bvalid_t  [4];
  logic  rvalid_t  [4];
  resp_t bresp_t   [4];
  resp_t rresp_t   [4];
  data_t rdata_t   [4];

  function automatic target_e decode(addr_t addr);
    if (addr >= ctrl_base_addr && addr <= ctrl_end_addr) return tgt_ctrl;
    if (addr >= l2_base_addr && addr <= l2_end_addr) return tgt_l2;
    if (addr >= bootrom_base_addr && addr <= bootrom_end_addr) return tgt_bootrom;
    return tgt_none;
  endfunction

  assign aw_sel = decode(slv.awaddr);
  assign ar_sel = decode(slv.araddr);

  // Unmapped accesses are taken here and answered one cycle later
  assign awready_t = '{ctrl_mst.awready, l2_mst.awready, rom_mst.awready,
                       slv.awvalid && slv.wvalid};
  assign wready_t  = '{ctrl_mst.wready, l2_mst.wready, rom_mst.wready,
                       slv.awvalid && slv.wvalid};
  assign arready_t = '{ctrl_mst.arready, l2_mst.arready, rom_mst.arready, slv.arvalid};
  assign bvalid_t  = '{ctrl_mst.bvalid, l2_mst.bvalid, rom_mst.bvalid, 1'b1};
  assign rvalid_t  = '{ctrl_mst.rvalid, l2_mst.rvalid, rom_mst.rvalid, 1'b1};
  assign bresp_t   = '{ctrl_mst.bresp, l2_mst.bresp, rom_mst.bresp, resp_decerr};
  assign rresp_t   = '{ctrl_mst.rresp, l2_mst.rresp, rom_mst.rresp, resp_decerr};
  assign rdata_t   = '{ctrl_mst.rdata, l2_mst.rdata, rom_mst.rdata, '0};

  assign slv.awready = !w_busy && awready_t[aw_sel];
  assign slv.wready  = !w_busy && wready_t[aw_sel];
  assign slv.arready = !r_busy && arready_t[ar_sel];
  assign slv.bvalid  = w_busy && bvalid_t[w_tgt];
  assign slv.bresp   = bresp_t[w_tgt];
  assign slv.rvalid  = r_busy && rvalid_t[r_tgt];
  assign slv.rresp   = rresp_t[r_tgt];
  assign slv.rdata   = rdata_t[r_tgt];

  // Payload fans out to every target and valids reach only the decoded one
  assign ctrl_mst.awaddr  = slv.awaddr;
  assign ctrl_mst.wdata   = slv.wdata;
  assign ctrl_mst.wstrb   = slv.wstrb;
  assign ctrl_mst.araddr  = slv.araddr;
  assign ctrl_mst.awvalid = slv.awvalid && !w_busy && aw_sel == tgt_ctrl;
  assign ctrl_mst.wvalid  = slv.wvalid && !w_busy && aw_sel == tgt_ctrl;
  assign ctrl_mst.arvalid = slv.arvalid && !r_busy && ar_sel == tgt_ctrl;
  assign ctrl_mst.bready  = slv.bready && w_busy && w_tgt == tgt_ctrl;
  assign ctrl_mst.rready  = slv.rready && r_busy && r_tgt == tgt_ctrl;

  assign l2_mst.awaddr  = slv.awaddr;
  assign l2_mst.wdata   = slv.wdata;
  assign l2_mst.wstrb   = slv.wstrb;
  assign l2_mst.araddr  = slv.araddr;
  assign l2_mst.awvalid = slv.awvalid && !w_busy && aw_sel == tgt_l2;
  assign l2_mst.wvalid  = slv.wvalid && !w_busy && aw_sel == tgt_l2;
  assign l2_mst.arvalid = slv.arvalid && !r_busy && ar_sel == tgt_l2;
  assign l2_mst.bready  = slv.bready && w_busy && w_tgt == tgt_l2;
  assign l2_mst.rready  = slv.rready && r_busy && r_tgt == tgt_l2;

  assign rom_mst.awaddr  = slv.awaddr;
  assign rom_mst.wdata   = slv.wdata;
  assign rom_mst.wstrb   = slv.wstrb;
  assign rom_mst.araddr  = slv.araddr;
  assign rom_mst.awvalid = slv.awvalid && !w_busy && aw_sel == tgt_bootrom;
  assign rom_mst.wvalid  = slv.wvalid && !w_busy && aw_sel == tgt_bootrom;
  assign rom_mst.arvalid = slv.arvalid && !r_busy && ar_sel == tgt_bootrom;
  assign rom_mst.bready  = slv.bready && w_busy && w_tgt == tgt_bootrom;
  assign rom_mst.rready  = slv.rready && r_busy && r_tgt == tgt_bootrom;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_busy <= 1'b0;
      r_busy <= 1'b0;
      w_tgt  <= tgt_none;
      r_tgt  <= tgt_none;
    end else begin
      if (slv.awvalid && slv.awready) begin
        w_busy <= 1'b1;
        w_tgt  <= aw_sel;
      end else if (slv.bvalid && slv.bready) begin
        w_busy <= 1'b0;
      end
      if (slv.arvalid && slv.arready) begin
        r_busy <= 1'b1;
        r_tgt  <= ar_sel;
      end else if (slv.rvalid && slv.rready) begin
        r_busy <= 1'b0;
      end
    end
  end

  // Response routing must not move while a transaction is open
  assert property (@(posedge clk_i) disable iff (reset_i)
    w_busy && !(slv.bvalid && slv.bready) |=> w_busy && $stable(w_tgt));
  assert property (@(posedge clk_i) disable iff (reset_i)
    r_busy && !(slv.rvalid && slv.rready) |=> r_busy && $stable(r_tgt));

endmodule

// ==== rtl/axi_lite_if.sv ====
`timescale 1ns/10ps

interface axi_lite_if;
  import axi_lite_pkg::*;

  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// ==== rtl/mempool_system_pkg.sv ====
package mempool_system_pkg;

  // Host address map
  localparam logic [31:0] ctrl_base_addr    = 32'h4000_0000;
  localparam logic [31:0] ctrl_end_addr     = 32'h4000_FFFF;
  localparam logic [31:0] l2_base_addr      = 32'h8000_0000;
  localparam logic [31:0] l2_end_addr       = 32'h8000_0FFF;
  localparam logic [31:0] bootrom_base_addr = 32'hA000_0000;
  localparam logic [31:0] bootrom_end_addr  = 32'hA000_00FF;

  typedef enum logic [1:0] {
    tgt_ctrl,
    tgt_l2,
    tgt_bootrom,
    tgt_none
  } target_e;

  // Control register offsets
  localparam logic [15:0] reg_eoc_off        = 16'h0000;
  localparam logic [15:0] reg_wake_up_off    = 16'h0004;
  localparam logic [15:0] reg_tcdm_start_off = 16'h0008;
  localparam logic [15:0] reg_tcdm_end_off   = 16'h000C;
  localparam logic [15:0] reg_num_cores_off  = 16'h0010;
  localparam logic [15:0] reg_busy_off       = 16'h0014;

  localparam int unsigned bootrom_num_words = 64;
  localparam logic [31:0] bootrom_pattern   = 32'hB007_0000;

endpackage

// ==== rtl/axi_lite_pkg.sv ====
package axi_lite_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;
  localparam resp_t resp_decerr = 2'b11;

endpackage
